// ==== simt_core.f ====
design/simt_pkg.sv
design/simt_if.sv
design/simt_fetch.sv
design/simt_decode.sv
design/simt_execute.sv
design/simt_result.sv
design/simt_core.sv
sim/simt_clock_gen.sv
sim/simt_core_assert.sv
sim/simt_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f simt_core.f --top-module simt_core_tb \
	-o simt_core_sim > build.log 2>&1 && ./obj_dir/simt_core_sim > sim.log 2>&1
grep -q "^Result: PASSED$" sim.log && echo "simulation ok" || { echo "simulation not ok"; exit 1; }

// ==== sim/simt_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module simt_core_tb;

	typedef struct packed {
		logic [simt_pkg::reg_bits-1:0] rd;
		logic [simt_pkg::xlen-1:0]     base;
		logic [simt_pkg::xlen-1:0]     lane_step;
		logic [simt_pkg::xlen-1:0]     warp_step;
		simt_pkg::lane_mask_t          mask;
	} wb_entry_t;

	logic                           clk;
	logic                           reset;
	logic [simt_pkg::xlen-1:0]      imem_addr;
	logic [simt_pkg::xlen-1:0]      instr;
	logic                           freeze;
	logic                           wb_valid;
	logic [simt_pkg::warp_bits-1:0] wb_warp;
	logic [simt_pkg::reg_bits-1:0]  wb_rd;
	simt_pkg::lane_mask_t           wb_mask;
	simt_pkg::lane_data_t           wb_data;
	logic                           idle;

	logic [simt_pkg::xlen-1:0] program_words [$];
	wb_entry_t                 expected [$];
	int                        next_entry [simt_pkg::num_warps];
	logic [31:0]               rnd_state;
	int                        cycles = 0;
	bit                        run_over;

	simt_clock_gen clock_gen (.clk(clk), .reset(reset));

	simt_core DUT (
		.clk       (clk),
		.reset     (reset),
		.imem_addr (imem_addr),
		.instr     (instr),
		.freeze    (freeze),
		.wb_valid  (wb_valid),
		.wb_warp   (wb_warp),
		.wb_rd     (wb_rd),
		.wb_mask   (wb_mask),
		.wb_data   (wb_data),
		.idle      (idle)
	);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic emit(input logic [3:0] op, input logic [3:0] rd, input logic [3:0] rs1,
		input logic [3:0] rs2, input logic [15:0] imm);
		program_words.push_back({op, rd, rs1, rs2, imm});
	endtask

	task automatic expect_wb(input logic [3:0] rd, input logic [31:0] base,
		input logic [31:0] lane_step, input logic [31:0] warp_step,
		input simt_pkg::lane_mask_t mask);
		wb_entry_t e;
		e.rd        = rd;
		e.base      = base;
		e.lane_step = lane_step;
		e.warp_step = warp_step;
		e.mask      = mask;
		expected.push_back(e);
	endtask

	task automatic build_program();
		emit(simt_pkg::op_lid,  4'd1,  4'd0,  4'd0, 16'h0000);
		emit(simt_pkg::op_wid,  4'd2,  4'd0,  4'd0, 16'h0000);
		emit(simt_pkg::op_addi, 4'd3,  4'd1,  4'd0, 16'h0005);
		emit(simt_pkg::op_add,  4'd4,  4'd1,  4'd2, 16'h0000);
		emit(simt_pkg::op_sub,  4'd5,  4'd3,  4'd2, 16'h0000);
		emit(simt_pkg::op_xor,  4'd6,  4'd1,  4'd1, 16'h0000); // Zero register.
		emit(simt_pkg::op_addi, 4'd7,  4'd6,  4'd0, 16'h0100);
		emit(simt_pkg::op_xor,  4'd8,  4'd1,  4'd7, 16'h0000);
		emit(simt_pkg::op_add,  4'd9,  4'd4,  4'd2, 16'h0000);
		emit(4'hf,              4'd1,  4'd1,  4'd0, 16'h0000); // Unknown code writes nothing.
		emit(simt_pkg::op_jal,  4'd10, 4'd0,  4'd0, 16'h0008);
		emit(simt_pkg::op_addi, 4'd11, 4'd6,  4'd0, 16'h0077); // Skipped by the jump.
		emit(simt_pkg::op_addi, 4'd12, 4'd6,  4'd0, 16'h0003);
		emit(simt_pkg::op_addi, 4'd12, 4'd12, 4'd0, 16'hffff); // Loop head at 0x34.
		emit(simt_pkg::op_bnz,  4'd0,  4'd12, 4'd0, 16'hfffc);
		emit(simt_pkg::op_addi, 4'd14, 4'd6,  4'd0, 16'h0003);
		emit(simt_pkg::op_tmc,  4'd0,  4'd14, 4'd0, 16'h0000); // Lanes 0 and 1 only.
		emit(simt_pkg::op_addi, 4'd15, 4'd1,  4'd0, 16'h0020);
		emit(simt_pkg::op_tmc,  4'd0,  4'd6,  4'd0, 16'h0000); // Halts the warp.
	endtask

	task automatic build_expected();
		expect_wb(4'd1,  32'h0,     32'd1, 32'd0,        4'hf);
		expect_wb(4'd2,  32'h0,     32'd0, 32'd1,        4'hf);
		expect_wb(4'd3,  32'h5,     32'd1, 32'd0,        4'hf);
		expect_wb(4'd4,  32'h0,     32'd1, 32'd1,        4'hf);
		expect_wb(4'd5,  32'h5,     32'd1, 32'hffffffff, 4'hf);
		expect_wb(4'd6,  32'h0,     32'd0, 32'd0,        4'hf);
		expect_wb(4'd7,  32'h100,   32'd0, 32'd0,        4'hf);
		expect_wb(4'd8,  32'h100,   32'd1, 32'd0,        4'hf);
		expect_wb(4'd9,  32'h0,     32'd1, 32'd2,        4'hf);
		expect_wb(4'd10, 32'h2c,    32'd0, 32'd0,        4'hf); // Link of the jump at 0x28.
		expect_wb(4'd12, 32'h3,     32'd0, 32'd0,        4'hf);
		expect_wb(4'd12, 32'h2,     32'd0, 32'd0,        4'hf);
		expect_wb(4'd12, 32'h1,     32'd0, 32'd0,        4'hf);
		expect_wb(4'd12, 32'h0,     32'd0, 32'd0,        4'hf);
		expect_wb(4'd14, 32'h3,     32'd0, 32'd0,        4'hf);
		expect_wb(4'd15, 32'h20,    32'd1, 32'd0,        4'h3);
	endtask

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] imem_read(input logic [31:0] addr);
		if ((addr >> 2) < program_words.size())
			return program_words[addr >> 2];
		return 32'h0; // Nop outside the program.
	endfunction

	function automatic bit warps_finished();
		bit done;
		done = 1'b1;
		for (int w = 0; w < simt_pkg::num_warps; w++) begin
			if (next_entry[w] != expected.size())
				done = 1'b0;
		end
		return done;
	endfunction

	task automatic compare_rd(input logic [simt_pkg::reg_bits-1:0] actual,
		input logic [simt_pkg::reg_bits-1:0] exp_rd);
		if (actual !== exp_rd)
			report_failure($sformatf("mismatch wb_rd: got %h expected %h", actual, exp_rd));
	endtask

	task automatic compare_mask(input simt_pkg::lane_mask_t actual,
		input simt_pkg::lane_mask_t exp_mask);
		if (actual !== exp_mask)
			report_failure($sformatf("mismatch wb_mask: got %h expected %h", actual, exp_mask));
	endtask

	task automatic compare_data(input simt_pkg::lane_data_t actual,
		input simt_pkg::lane_data_t exp_data, input simt_pkg::lane_mask_t mask);
		for (int l = 0; l < simt_pkg::num_threads; l++) begin
			if (mask[l] && (actual[l] !== exp_data[l]))
				report_failure($sformatf("mismatch wb_data[%0d]: got %h expected %h",
					l, actual[l], exp_data[l]));
		end
	endtask

	task automatic check_writeback();
		wb_entry_t            e;
		simt_pkg::lane_data_t exp_data;
		int                   w;
		w = int'(wb_warp);
		if (next_entry[w] >= expected.size()) begin
			report_failure($sformatf("warp %0d wrote back after its last expected entry", w));
		end else begin
			e = expected[next_entry[w]];
			for (int l = 0; l < simt_pkg::num_threads; l++)
				exp_data[l] = e.base + 32'(l) * e.lane_step + 32'(w) * e.warp_step;
			compare_rd(wb_rd, e.rd);
			compare_mask(wb_mask, e.mask);
			compare_data(wb_data, exp_data, e.mask); // Inactive lanes are ignored.
			next_entry[w]++;
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= (expected.size() + 16) * simt_pkg::num_warps * 4)
			report_failure("timeout: the warps did not all halt in time");
	end

	initial begin
		instr     = '0;
		freeze    = 1'b0;
		rnd_state = 32'ha7b4_c338;
		run_over  = 1'b0;
		for (int w = 0; w < simt_pkg::num_warps; w++)
			next_entry[w] = 0;
		build_program();
		build_expected();
		while (!run_over) begin
			@(negedge clk);
			if (reset) begin
				if (wb_valid !== 1'b0 || idle !== 1'b0)
					report_failure("wb_valid or idle is not low during reset");
			end else begin
				if (wb_valid)
					check_writeback();
				if (idle) begin
					if (!warps_finished())
						report_failure("idle went high before every warp finished");
					run_over = 1'b1;
				end
			end
			rnd_state = next_random(rnd_state);
			freeze    = (rnd_state[1:0] == 2'b00); // About one slot in four.
			instr     = imem_read(imem_addr);
		end
		if (warps_finished() && idle && (DUT.u_assert.fail_count == 0)) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			report_failure("run ended with missing writebacks or failed assertions");
		end
	end

endmodule

`default_nettype wire

// ==== sim/simt_core_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module simt_core_assert (
	input wire                                 clk,
	input wire                                 reset,
	input wire [simt_pkg::xlen-1:0]            imem_addr,
	input wire                                 wb_valid,
	input wire [simt_pkg::warp_bits-1:0]       wb_warp,
	input wire [simt_pkg::num_threads-1:0]     wb_mask,
	input wire [simt_pkg::warp_bits-1:0]       warp_cnt
);

	int unsigned fail_count = 0;

	wb_mask_active: assert property (@(posedge clk) disable iff (reset)
		wb_valid |-> (wb_mask != '0))
	else begin
		$error("writeback with an empty lane mask");
		fail_count++;
	end

	imem_aligned: assert property (@(posedge clk) disable iff (reset)
		imem_addr[1:0] == 2'b00)
	else begin
		$error("instruction address %h is not word aligned", imem_addr);
		fail_count++;
	end

	// Slot to writeback is three cycles.
	wb_warp_slot: assert property (@(posedge clk) disable iff (reset)
		wb_valid |-> (wb_warp == $past(warp_cnt, 3)))
	else begin
		$error("writeback warp %h does not match its issue slot", wb_warp);
		fail_count++;
	end

endmodule

bind simt_core simt_core_assert u_assert (
	.clk       (clk),
	.reset     (reset),
	.imem_addr (imem_addr),
	.wb_valid  (wb_valid),
	.wb_warp   (wb_warp),
	.wb_mask   (wb_mask),
	.warp_cnt  (u_fetch.warp_cnt)
);

`default_nettype wire

// ==== sim/simt_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module simt_clock_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk   = 1'b0;
		reset = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset <= 1'b0; // Released away from the rising edge.
	end

	always #50 clk = ~clk; // 100 ns period.

endmodule

`default_nettype wire

// ==== design/simt_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module simt_core (
	input  wire                                clk,
	input  wire                                reset,
	output logic [simt_pkg::xlen-1:0]          imem_addr,
	input  wire [simt_pkg::xlen-1:0]           instr,
	input  wire                                freeze,
	output logic                               wb_valid,
	output logic [simt_pkg::warp_bits-1:0]     wb_warp,
	output logic [simt_pkg::reg_bits-1:0]      wb_rd,
	output simt_pkg::lane_mask_t               wb_mask,
	output simt_pkg::lane_data_t               wb_data,
	output logic                               idle
);

	issue_if    issue_bus ();
	rf_read_if  rf_read_bus ();
	operand_if  operand_bus ();
	redirect_if redirect_bus ();
	exec_if     exec_bus ();

	simt_fetch u_fetch (
		.clk       (clk),
		.reset     (reset),
		.instr     (instr),
		.freeze    (freeze),
		.imem_addr (imem_addr),
		.idle      (idle),
		.issue     (issue_bus),
		.redirect  (redirect_bus)
	);

	simt_decode u_decode (
		.clk      (clk),
		.reset    (reset),
		.issue    (issue_bus),
		.rf_read  (rf_read_bus),
		.operands (operand_bus)
	);

	simt_execute u_execute (
		.clk      (clk),
		.reset    (reset),
		.operands (operand_bus),
		.redirect (redirect_bus),
		.exec     (exec_bus)
	);

	simt_result u_result (
		.clk      (clk),
		.reset    (reset),
		.rf_read  (rf_read_bus),
		.exec     (exec_bus),
		.wb_valid (wb_valid),
		.wb_warp  (wb_warp),
		.wb_rd    (wb_rd),
		.wb_mask  (wb_mask),
		.wb_data  (wb_data)
	);

endmodule

`default_nettype wire

// ==== design/simt_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module simt_result (
	input  wire                                clk,
	input  wire                                reset,
	rf_read_if.target                          rf_read,
	exec_if.sink                               exec,
	output logic                               wb_valid,
	output logic [simt_pkg::warp_bits-1:0]     wb_warp,
	output logic [simt_pkg::reg_bits-1:0]      wb_rd,
	output simt_pkg::lane_mask_t               wb_mask,
	output simt_pkg::lane_data_t               wb_data
);

	logic [simt_pkg::xlen-1:0] regs [simt_pkg::num_warps][simt_pkg::num_threads][simt_pkg::num_regs];

	always_comb begin
		for (int l = 0; l < simt_pkg::num_threads; l++) begin
			rf_read.rs1_data[l] = regs[rf_read.warp][l][rf_read.rs1];
			rf_read.rs2_data[l] = regs[rf_read.warp][l][rf_read.rs2];
		end
	end

	// Inactive lanes keep their old values.
	always_ff @(posedge clk) begin
		for (int l = 0; l < simt_pkg::num_threads; l++) begin
			if (exec.valid && exec.mask[l])
				regs[exec.warp][l][exec.rd] <= exec.data[l];
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			wb_valid <= 1'b0;
		else
			wb_valid <= exec.valid;
	end

	always_ff @(posedge clk) begin
		wb_warp <= exec.warp;
		wb_rd   <= exec.rd;
		wb_mask <= exec.mask;
		wb_data <= exec.data;
	end

endmodule

`default_nettype wire

// ==== design/simt_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module simt_execute (
	input  wire          clk,
	input  wire          reset,
	operand_if.sink      operands,
	redirect_if.source   redirect,
	exec_if.source       exec
);

	simt_pkg::lane_data_t      result;
	logic [simt_pkg::xlen-1:0] lead_rs1;
	logic [simt_pkg::xlen-1:0] link;
	logic [simt_pkg::xlen-1:0] target;
	logic                      taken;
	logic                      writes;

	// Lowest active lane decides branches and mask changes.
	always_comb begin
		lead_rs1 = '0;
		for (int l = simt_pkg::num_threads - 1; l >= 0; l--) begin
			if (operands.mask[l])
				lead_rs1 = operands.rs1_data[l];
		end
	end

	assign link   = operands.pc + simt_pkg::instr_bytes;
	assign taken  = (operands.op == simt_pkg::op_jal) ||
		((operands.op == simt_pkg::op_bnz) && (lead_rs1 != '0));
	assign target = taken ? operands.pc + operands.imm : link;

	always_comb begin
		for (int l = 0; l < simt_pkg::num_threads; l++) begin
			case (operands.op)
				simt_pkg::op_addi: result[l] = operands.rs1_data[l] + operands.imm;
				simt_pkg::op_add:  result[l] = operands.rs1_data[l] + operands.rs2_data[l];
				simt_pkg::op_sub:  result[l] = operands.rs1_data[l] - operands.rs2_data[l];
				simt_pkg::op_xor:  result[l] = operands.rs1_data[l] ^ operands.rs2_data[l];
				simt_pkg::op_lid:  result[l] = simt_pkg::xlen'(l);
				simt_pkg::op_wid:  result[l] = simt_pkg::xlen'(operands.warp);
				simt_pkg::op_jal:  result[l] = link;
				default:           result[l] = '0;
			endcase
		end
	end

	always_comb begin
		case (operands.op)
			simt_pkg::op_addi, simt_pkg::op_add, simt_pkg::op_sub, simt_pkg::op_xor,
			simt_pkg::op_lid, simt_pkg::op_wid, simt_pkg::op_jal:
				writes = 1'b1;
			default:
				writes = 1'b0;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			redirect.valid      <= 1'b0;
			redirect.mask_valid <= 1'b0;
			exec.valid          <= 1'b0;
		end else begin
			redirect.valid      <= operands.valid; // Every instruction sets the next PC.
			redirect.mask_valid <= operands.valid && (operands.op == simt_pkg::op_tmc);
			exec.valid          <= operands.valid && writes;
		end
	end

	always_ff @(posedge clk) begin
		redirect.warp     <= operands.warp;
		redirect.target   <= target;
		redirect.new_mask <= lead_rs1[simt_pkg::num_threads-1:0];
		exec.warp         <= operands.warp;
		exec.rd           <= operands.rd;
		exec.mask         <= operands.mask;
		exec.data         <= result;
	end

endmodule

`default_nettype wire

// ==== design/simt_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module simt_decode (
	input  wire         clk,
	input  wire         reset,
	issue_if.sink       issue,
	rf_read_if.source   rf_read,
	operand_if.source   operands
);

	logic [simt_pkg::opcode_msb-simt_pkg::opcode_lsb:0] op_code;
	simt_pkg::opcode_e                                  op;
	logic [simt_pkg::xlen-1:0]                          imm;

	assign op_code = issue.instr[simt_pkg::opcode_msb:simt_pkg::opcode_lsb];
	assign imm     = {{(simt_pkg::xlen - simt_pkg::imm_msb - 1){issue.instr[simt_pkg::imm_msb]}},
		issue.instr[simt_pkg::imm_msb:simt_pkg::imm_lsb]};

	// Unknown codes fall back to nop.
	always_comb begin
		case (simt_pkg::opcode_e'(op_code))
			simt_pkg::op_addi, simt_pkg::op_add, simt_pkg::op_sub,
			simt_pkg::op_xor, simt_pkg::op_lid, simt_pkg::op_wid,
			simt_pkg::op_jal, simt_pkg::op_bnz, simt_pkg::op_tmc:
				op = simt_pkg::opcode_e'(op_code);
			default:
				op = simt_pkg::op_nop;
		endcase
	end

	assign rf_read.warp = issue.warp;
	assign rf_read.rs1  = issue.instr[simt_pkg::rs1_msb:simt_pkg::rs1_lsb];
	assign rf_read.rs2  = issue.instr[simt_pkg::rs2_msb:simt_pkg::rs2_lsb];

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			operands.valid <= 1'b0;
		else
			operands.valid <= issue.valid;
	end

	always_ff @(posedge clk) begin
		operands.warp     <= issue.warp;
		operands.pc       <= issue.pc;
		operands.op       <= op;
		operands.rd       <= issue.instr[simt_pkg::rd_msb:simt_pkg::rd_lsb];
		operands.imm      <= imm;
		operands.rs1_data <= rf_read.rs1_data; // Register file answers in the same cycle.
		operands.rs2_data <= rf_read.rs2_data;
		operands.mask     <= issue.mask;
	end

endmodule

`default_nettype wire

// ==== design/simt_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module simt_fetch (
	input  wire                         clk,
	input  wire                         reset,
	input  wire [simt_pkg::xlen-1:0]    instr,
	input  wire                         freeze,
	output logic [simt_pkg::xlen-1:0]   imem_addr,
	output logic                        idle,
	issue_if.source                     issue,
	redirect_if.sink                    redirect
);

	logic [simt_pkg::warp_bits-1:0] warp_cnt;
	logic [simt_pkg::xlen-1:0]      pc_q [simt_pkg::num_warps];
	simt_pkg::lane_mask_t           mask_q [simt_pkg::num_warps];
	logic [2:0]                     inflight; // Issue history, one bit per stage.
	logic                           all_halted;

	// The slot belongs to the warp under the counter.
	assign imem_addr   = pc_q[warp_cnt];
	assign issue.valid = !freeze && (mask_q[warp_cnt] != '0);
	assign issue.warp  = warp_cnt;
	assign issue.pc    = pc_q[warp_cnt];
	assign issue.instr = instr;
	assign issue.mask  = mask_q[warp_cnt];

	always_comb begin
		all_halted = 1'b1;
		for (int w = 0; w < simt_pkg::num_warps; w++) begin
			if (mask_q[w] != '0)
				all_halted = 1'b0;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			warp_cnt <= '0;
			inflight <= '0;
			idle     <= 1'b0;
			for (int w = 0; w < simt_pkg::num_warps; w++) begin
				pc_q[w]   <= simt_pkg::reset_pc;
				mask_q[w] <= simt_pkg::reset_mask;
			end
		end else begin
			warp_cnt <= warp_cnt + 1'b1; // Advances on bubbles too.
			inflight <= {inflight[1:0], issue.valid};
			idle     <= all_halted && (inflight == '0);
			for (int w = 0; w < simt_pkg::num_warps; w++) begin
				// Redirect and issue never hit the same warp in one cycle.
				if (redirect.valid && (redirect.warp == simt_pkg::warp_bits'(w))) begin
					pc_q[w] <= redirect.target;
					if (redirect.mask_valid)
						mask_q[w] <= redirect.new_mask; // Zero halts the warp.
				end else if (issue.valid && (warp_cnt == simt_pkg::warp_bits'(w))) begin
					pc_q[w] <= pc_q[w] + simt_pkg::instr_bytes;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/simt_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface issue_if;
	logic                           valid;
	logic [simt_pkg::warp_bits-1:0] warp;
	logic [simt_pkg::xlen-1:0]      pc;
	logic [simt_pkg::xlen-1:0]      instr;
	simt_pkg::lane_mask_t           mask;

	modport source (output valid, warp, pc, instr, mask);
	modport sink   (input valid, warp, pc, instr, mask);
endinterface

interface rf_read_if;
	logic [simt_pkg::warp_bits-1:0] warp;
	logic [simt_pkg::reg_bits-1:0]  rs1;
	logic [simt_pkg::reg_bits-1:0]  rs2;
	simt_pkg::lane_data_t           rs1_data;
	simt_pkg::lane_data_t           rs2_data;

	modport source (output warp, rs1, rs2, input rs1_data, rs2_data);
	modport target (input warp, rs1, rs2, output rs1_data, rs2_data);
endinterface

interface operand_if;
	logic                           valid;
	logic [simt_pkg::warp_bits-1:0] warp;
	logic [simt_pkg::xlen-1:0]      pc;
	simt_pkg::opcode_e              op;
	logic [simt_pkg::reg_bits-1:0]  rd;
	logic [simt_pkg::xlen-1:0]      imm;
	simt_pkg::lane_data_t           rs1_data;
	simt_pkg::lane_data_t           rs2_data;
	simt_pkg::lane_mask_t           mask;

	modport source (output valid, warp, pc, op, rd, imm, rs1_data, rs2_data, mask);
	modport sink   (input valid, warp, pc, op, rd, imm, rs1_data, rs2_data, mask);
endinterface

interface redirect_if;
	logic                           valid;
	logic [simt_pkg::warp_bits-1:0] warp;
	logic [simt_pkg::xlen-1:0]      target;
	logic                           mask_valid;
	simt_pkg::lane_mask_t           new_mask;

	modport source (output valid, warp, target, mask_valid, new_mask);
	modport sink   (input valid, warp, target, mask_valid, new_mask);
endinterface

interface exec_if;
	logic                           valid;
	logic [simt_pkg::warp_bits-1:0] warp;
	logic [simt_pkg::reg_bits-1:0]  rd;
	simt_pkg::lane_mask_t           mask;
	simt_pkg::lane_data_t           data;

	modport source (output valid, warp, rd, mask, data);
	modport sink   (input valid, warp, rd, mask, data);
endinterface

`default_nettype wire

// ==== design/simt_pkg.sv ====
`default_nettype none

package simt_pkg;

	localparam int num_warps   = 4;
	localparam int warp_bits   = 2;
	localparam int num_threads = 4;
	localparam int xlen        = 32;
	localparam int num_regs    = 16;
	localparam int reg_bits    = 4;

	localparam logic [xlen-1:0] reset_pc    = '0;
	localparam logic [xlen-1:0] instr_bytes = 4; // Fixed instruction size.

	// Instruction field positions.
	localparam int opcode_msb = 31;
	localparam int opcode_lsb = 28;
	localparam int rd_msb     = 27;
	localparam int rd_lsb     = 24;
	localparam int rs1_msb    = 23;
	localparam int rs1_lsb    = 20;
	localparam int rs2_msb    = 19;
	localparam int rs2_lsb    = 16;
	localparam int imm_msb    = 15;
	localparam int imm_lsb    = 0;

	typedef enum logic [3:0] {
		op_nop  = 4'h0,
		op_addi = 4'h1,
		op_add  = 4'h2,
		op_sub  = 4'h3,
		op_xor  = 4'h4,
		op_lid  = 4'h5,
		op_wid  = 4'h6,
		op_jal  = 4'h7,
		op_bnz  = 4'h8,
		op_tmc  = 4'h9
	} opcode_e;

	typedef logic [num_threads-1:0][xlen-1:0] lane_data_t;
	typedef logic [num_threads-1:0]           lane_mask_t;

	localparam lane_mask_t reset_mask = '1; // All lanes active.

endpackage

`default_nettype wire
